// File: dv/lc4_pipe_core_tb.sv
// Testbench for the LC4 pipelined core with memory models, test data reader and retire scoreboard
module lc4_pipe_core_tb import isa_pkg::*, pipe_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int    RETIRE_TIMEOUT = 20;  // Cycles allowed between two retired instructions
   localparam int    MAX_REC        = 64;
   localparam word_t RESET_PC       = 16'h8200;

   logic   gwe;
   logic   rst_n;
   word_t  imem_data;
   word_t  dmem_rdata;
   word_t  imem_addr;
   word_t  dmem_addr;
   logic   dmem_we;
   word_t  dmem_wdata;
   trace_t trace;

   word_t  imem [65536];
   word_t  dmem [65536];
   trace_t exp_ret [MAX_REC];
   word_t  exp_st_addr [MAX_REC];
   word_t  exp_st_data [MAX_REC];
   int     n_ret;
   int     n_st;
   int     st_seen;
   int     exp_flush;
   int     exp_load_use;
   int     n_flush;
   int     n_load_use;
   integer seed;

   lc4_pipe_core #(
      .RESET_PC (RESET_PC)
   ) u_lc4_pipe_core (
      .gwe          (gwe),
      .i_rst_n      (rst_n),
      .i_imem_data  (imem_data),
      .i_dmem_rdata (dmem_rdata),
      .o_imem_addr  (imem_addr),
      .o_dmem_addr  (dmem_addr),
      .o_dmem_we    (dmem_we),
      .o_dmem_wdata (dmem_wdata),
      .o_trace      (trace)
   );

   // Both memories answer in the same cycle
   assign imem_data  = imem[imem_addr];
   assign dmem_rdata = dmem[dmem_addr];

   always @(posedge gwe) begin
      if (dmem_we === 1'b1) dmem[dmem_addr] <= dmem_wdata;
   end

   initial begin
      gwe = 1'b0;
      forever #10 gwe = ~gwe;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) report_failure($sformatf("ERR %s expected %h got %h", name, exp, act));
   endtask

   task automatic check_sel(input string name, input reg_sel_t exp, input reg_sel_t act);
      if (act !== exp) report_failure($sformatf("ERR %s expected %h got %h", name, exp, act));
   endtask

   task automatic check_nzp(input string name, input nzp_t exp, input nzp_t act);
      if (act !== exp) report_failure($sformatf("ERR %s expected %h got %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) report_failure($sformatf("ERR %s expected %h got %h", name, exp, act));
   endtask

   task automatic check_stall(input string name, input stall_t exp, input stall_t act);
      if (act !== exp) report_failure($sformatf("ERR %s expected %h got %h", name, exp, act));
   endtask

   task automatic fill_memories();
      seed = 32'ha068;
      for (int a = 0; a < 65536; a++) begin
         // Unused code words decode as no-ops, tagged with their address
         imem[a] = 16'hF000 | ((word_t'(a) ^ word_t'(a >> 12)) & 16'h0FFF);
         dmem[a] = word_t'($random(seed)) ^ word_t'(a);
      end
   endtask

   task automatic read_testdata();
      integer           fd;
      integer           n;
      integer           want;
      logic [63:0]      tag;
      logic [8*256-1:0] line;
      word_t            a;
      word_t            d;
      word_t            wd;
      logic [3:0]       f_we;
      logic [3:0]       f_sel;
      logic [3:0]       f_nwe;
      logic [3:0]       f_nzp;
      logic             done;
      fd = $fopen("dv/lc4_testdata.hex", "r");
      if (fd == 0) report_failure("Could not open the test data file dv/lc4_testdata.hex");
      done = 1'b0;
      while (!done) begin
         n = $fscanf(fd, "%s", tag);
         if (n != 1) begin
            done = 1'b1;
         end else begin
            case (tag)
               "#": begin
                  n    = $fgets(line, fd);     // Rest of a comment
                  want = n;
               end
               "P", "D", "S": begin
                  n    = $fscanf(fd, "%h %h", a, d);
                  want = 2;
                  if (tag == "P") imem[a] = d;
                  else if (tag == "D") dmem[a] = d;
                  else begin
                     exp_st_addr[n_st] = a;
                     exp_st_data[n_st] = d;
                     n_st++;
                  end
               end
               "R": begin
                  n    = $fscanf(fd, "%h %h %h %h %h %h %h", a, d, f_we, f_sel, wd, f_nwe, f_nzp);
                  want = 7;
                  exp_ret[n_ret] = '{stall: ST_NONE, pc: a, insn: d, rf_we: f_we[0],
                                     wsel: f_sel[2:0], wdata: wd, nzp_we: f_nwe[0],
                                     nzp: f_nzp[2:0]};
                  n_ret++;
               end
               "B": begin
                  n    = $fscanf(fd, "%h %h", exp_flush, exp_load_use);
                  want = 2;
               end
               default: report_failure("Unknown record tag in the test data file");
            endcase
            if (n != want) report_failure("Malformed record in the test data file");
         end
      end
      $fclose(fd);
      if (n_ret == 0) report_failure("The test data file holds no retire records");
   endtask

   // Store port against the expected store list
   task automatic check_store();
      if (dmem_we !== 1'b0) begin
         if (st_seen >= n_st) begin
            report_failure($sformatf("Unexpected store to address %h", dmem_addr));
         end
         check_word("o_dmem_addr", exp_st_addr[st_seen], dmem_addr);
         check_word("o_dmem_wdata", exp_st_data[st_seen], dmem_wdata);
         st_seen++;
      end
   endtask

   // Steps to the next retired instruction, counting bubbles on the way
   task automatic wait_retire(input int idx, output trace_t rec);
      int waited;
      waited = 0;
      do begin
         @(negedge gwe);
         waited++;
         if (waited > RETIRE_TIMEOUT) begin
            report_failure($sformatf("Timed out waiting for retire record %0d at pc %h",
                                     idx, exp_ret[idx].pc));
         end
         check_store();
         if (idx == 0 && trace.stall !== ST_NONE) begin  // Nothing retired since reset
            check_stall("o_trace.stall", ST_FLUSH, trace.stall);
            check_bit("o_trace.rf_we", 1'b0, trace.rf_we);
            check_bit("o_trace.nzp_we", 1'b0, trace.nzp_we);
            check_bit("o_dmem_we", 1'b0, dmem_we);
         end else if (trace.stall === ST_FLUSH) begin
            n_flush++;
         end else if (trace.stall === ST_LOAD_USE) begin
            n_load_use++;
         end else if (trace.stall !== ST_NONE) begin
            report_failure($sformatf("ERR o_trace.stall holds an unknown code %h", trace.stall));
         end
      end while (trace.stall !== ST_NONE);
      rec = trace;
   endtask

   task automatic compare_retire(input trace_t exp, input trace_t got);
      check_word("o_trace.pc", exp.pc, got.pc);
      check_word("o_trace.insn", exp.insn, got.insn);
      check_bit("o_trace.rf_we", exp.rf_we, got.rf_we);
      if (exp.rf_we) begin
         check_sel("o_trace.wsel", exp.wsel, got.wsel);
         check_word("o_trace.wdata", exp.wdata, got.wdata);
      end
      check_bit("o_trace.nzp_we", exp.nzp_we, got.nzp_we);
      if (exp.nzp_we) check_nzp("o_trace.nzp", exp.nzp, got.nzp);
   endtask

   initial begin
      trace_t got;
      rst_n        = 1'b0;
      n_ret        = 0;
      n_st         = 0;
      st_seen      = 0;
      exp_flush    = 0;
      exp_load_use = 0;
      n_flush      = 0;
      n_load_use   = 0;
      fill_memories();
      read_testdata();
      repeat (3) @(posedge gwe);
      rst_n <= 1'b1;
      @(negedge gwe);
      check_word("o_imem_addr", RESET_PC, imem_addr);  // First fetch after reset
      for (int i = 0; i < n_ret; i++) begin
         wait_retire(i, got);
         compare_retire(exp_ret[i], got);
      end
      check_word("store count", word_t'(n_st), word_t'(st_seen));
      if (n_flush != exp_flush || n_load_use != exp_load_use) begin
         report_failure($sformatf("ERR bubble counts flush/load_use expected %h/%h got %h/%h",
                                  exp_flush, exp_load_use, n_flush, n_load_use));
      end else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

// File: dv/lc4_testdata.hex
# Tags: P addr word = program, D addr word = initial data, S addr data = expected store
# R pc insn rf_we wsel wdata nzp_we nzp = expected retire, B flush load_use = bubble counts
# Program at 8200h
P 8200 9205 # CONST R1 5
P 8201 95FD # CONST R2 -3
P 8202 1642 # ADD R3 R1 R2
P 8203 18D1 # SUB R4 R3 R1
P 8204 5B02 # AND R5 R4 R2
P 8205 1B63 # ADD R5 R5 3
P 8206 9C20 # CONST R6 20h
P 8207 6F81 # LDR R7 R6 1
P 8208 11C1 # ADD R0 R7 R1 after load
P 8209 7182 # STR R0 R6 2
P 820A 6382 # LDR R1 R6 2
P 820B 7383 # STR R1 R6 3 after load
P 820C 6580 # LDR R2 R6 0
P 820D 0402 # BRz 2 after load, taken
P 820E 9601 # squashed
P 820F 9602 # squashed
P 8210 0805 # BRn 5, not taken
P 8211 18BF # ADD R4 R2 -1
P 8212 0801 # BRn 1, taken
P 8213 9A07 # squashed
P 8214 F123 # outside the subset
P 8215 7984 # STR R4 R6 4
P 8216 1B03 # ADD R5 R4 R3
P 8217 9600 # CONST R3 0
P 8218 7B85 # STR R5 R6 5
P 8219 0401 # BRz 1, taken on memory NZP
P 821A 9E09 # squashed
P 821B 5F44 # AND R7 R5 R4
# Initial data
D 0020 0000
D 0021 8123
D 0022 5A5A
# Expected stores
S 0022 8128
S 0023 8128
S 0024 FFFF
S 0025 0001
# Expected retire records
R 8200 9205 1 1 0005 1 1
R 8201 95FD 1 2 FFFD 1 4
R 8202 1642 1 3 0002 1 1
R 8203 18D1 1 4 FFFD 1 4
R 8204 5B02 1 5 FFFD 1 4
R 8205 1B63 1 5 0000 1 2
R 8206 9C20 1 6 0020 1 1
R 8207 6F81 1 7 8123 1 4
R 8208 11C1 1 0 8128 1 4
R 8209 7182 0 0 0000 0 0
R 820A 6382 1 1 8128 1 4
R 820B 7383 0 0 0000 0 0
R 820C 6580 1 2 0000 1 2
R 820D 0402 0 0 0000 0 0
R 8210 0805 0 0 0000 0 0
R 8211 18BF 1 4 FFFF 1 4
R 8212 0801 0 0 0000 0 0
R 8214 F123 0 0 0000 0 0
R 8215 7984 0 0 0000 0 0
R 8216 1B03 1 5 0001 1 1
R 8217 9600 1 3 0000 1 2
R 8218 7B85 0 0 0000 0 0
R 8219 0401 0 0 0000 0 0
R 821B 5F44 1 7 0001 1 1
# Bubbles between first and last retire
B 6 3

// File: lc4_pipe_core.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/lc4_decoder.sv
src/lc4_regfile.sv
src/lc4_fetch.sv
src/lc4_decode_stage.sv
src/lc4_execute_stage.sv
src/lc4_mem_wb.sv
src/lc4_pipe_core.sv
dv/lc4_pipe_core_tb.sv

// File: src/isa_pkg.sv
// ISA word types, opcode and ALU enums, instruction field positions and the NZP helper
package isa_pkg;

   typedef logic [15:0] word_t;      // Data, address and instruction word
   typedef logic [2:0]  reg_sel_t;
   typedef logic [2:0]  nzp_t;       // One-hot, N is bit 2

   typedef enum logic [3:0] {
      OP_BR    = 4'd0,
      OP_ARITH = 4'd1,
      OP_LOGIC = 4'd5,
      OP_LDR   = 4'd6,
      OP_STR   = 4'd7,
      OP_CONST = 4'd9
   } opcode_t;

   typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_PASS_B, ALU_BR_TARGET} alu_op_t;

   // Immediate that replaces operand B
   typedef enum logic [1:0] {IMM_NONE, IMM_5, IMM_6, IMM_9} imm_sel_t;

   localparam int OPC_LSB   = 12;  // Opcode is [15:12]
   localparam int RD_LSB    = 9;   // Also the BR mask and the STR data register
   localparam int RS_LSB    = 6;
   localparam int RT_LSB    = 0;
   localparam int SUBOP_LSB = 3;
   localparam int IMM_FLAG  = 5;
   localparam int IMM5_W    = 5;
   localparam int IMM6_W    = 6;
   localparam int IMM9_W    = 9;

   localparam logic [2:0] SUBOP_ADD = 3'b000;
   localparam logic [2:0] SUBOP_SUB = 3'b010;
   localparam logic [2:0] SUBOP_AND = 3'b000;

   localparam word_t NOP_INSN = 16'h0000;  // BR with an empty mask, never taken

   // Condition code of a result
   function automatic nzp_t nzp_of(word_t value);
      if (value[15]) return 3'b100;
      else if (value == '0) return 3'b010;
      else return 3'b001;
   endfunction

endpackage

// File: src/lc4_decode_stage.sv
// Decode stage with register read, load-use hazard, branch resolution and the execute register
module lc4_decode_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic   gwe,
   input  logic   i_rst_n,
   input  d_reg_t i_d_reg,
   input  fwd_t   i_x_fwd,
   input  fwd_t   i_m_fwd,
   input  fwd_t   i_w_fwd,
   input  nzp_t   i_nzp_reg,
   output x_reg_t o_x_reg,
   output logic   o_load_use,
   output logic   o_branch_taken
);

   ctrl_t  ctrl;
   word_t  rs_rf;
   word_t  rt_rf;
   word_t  rs_data;
   word_t  rt_data;
   logic   d_valid;
   logic   reads_r1;
   logic   reads_r2;
   logic   hit_r1;
   logic   hit_r2;
   nzp_t   cond;
   x_reg_t x_q;

   lc4_decoder u_decoder (
      .i_insn (i_d_reg.insn),
      .o_ctrl (ctrl)
   );

   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_rst_n   (i_rst_n),
      .i_rs      (ctrl.r1sel),
      .i_rt      (ctrl.r2sel),
      .i_rd      (i_w_fwd.wsel),
      .i_wdata   (i_w_fwd.data),
      .i_rd_we   (i_w_fwd.rf_we),
      .o_rs_data (rs_rf),
      .o_rt_data (rt_rf)
   );

   // Writeback to decode bypass
   assign rs_data = (i_w_fwd.rf_we && i_w_fwd.wsel == ctrl.r1sel) ? i_w_fwd.data : rs_rf;
   assign rt_data = (i_w_fwd.rf_we && i_w_fwd.wsel == ctrl.r2sel) ? i_w_fwd.data : rt_rf;

   assign d_valid  = (i_d_reg.stall == ST_NONE);
   assign reads_r1 = ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND};
   assign reads_r2 = (reads_r1 && ctrl.imm_sel == IMM_NONE) || ctrl.is_store;
   assign hit_r1   = reads_r1 && (i_x_fwd.wsel == ctrl.r1sel);
   assign hit_r2   = reads_r2 && (i_x_fwd.wsel == ctrl.r2sel);

   // A load's value and its NZP are known only once memory answers
   assign o_load_use = d_valid && i_x_fwd.is_load && (hit_r1 || hit_r2 || ctrl.is_branch);

   // Youngest NZP writer wins
   always_comb begin
      if (i_x_fwd.nzp_we)      cond = i_x_fwd.nzp;
      else if (i_m_fwd.nzp_we) cond = i_m_fwd.nzp;
      else if (i_w_fwd.nzp_we) cond = i_w_fwd.nzp;
      else                     cond = i_nzp_reg;
   end

   assign o_branch_taken = d_valid && !o_load_use && ctrl.is_branch &&
                           |(i_d_reg.insn[RD_LSB +: 3] & cond);

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         x_q       <= '0;
         x_q.stall <= ST_FLUSH;
      end else if (!d_valid || o_load_use) begin
         x_q       <= '0;                 // Bubble, nothing written
         x_q.insn  <= NOP_INSN;
         x_q.pc    <= i_d_reg.pc;
         x_q.stall <= d_valid ? ST_LOAD_USE : i_d_reg.stall;
      end else begin
         x_q <= '{insn: i_d_reg.insn, pc: i_d_reg.pc, stall: ST_NONE, ctrl: ctrl,
                  r1_data: rs_data, r2_data: rt_data, take_branch: o_branch_taken};
      end
   end

   assign o_x_reg = x_q;

endmodule

// File: src/lc4_decoder.sv
// Instruction decoder for the LC4 subset, word to control struct
module lc4_decoder import isa_pkg::*, pipe_pkg::*; (
   input  word_t i_insn,
   output ctrl_t o_ctrl
);

   opcode_t    opcode;
   logic [2:0] subop;
   logic       imm_flag;

   assign opcode   = opcode_t'(i_insn[OPC_LSB +: 4]);
   assign subop    = i_insn[SUBOP_LSB +: 3];
   assign imm_flag = i_insn[IMM_FLAG];

   always_comb begin
      o_ctrl        = '0;
      o_ctrl.alu_op = ALU_PASS_B;            // Reads no registers
      o_ctrl.wsel   = i_insn[RD_LSB +: 3];
      o_ctrl.r1sel  = i_insn[RS_LSB +: 3];
      o_ctrl.r2sel  = i_insn[RT_LSB +: 3];
      case (opcode)
         OP_BR: begin
            o_ctrl.alu_op    = ALU_BR_TARGET;
            o_ctrl.imm_sel   = IMM_9;
            o_ctrl.is_branch = 1'b1;
         end
         OP_ARITH: begin
            if (imm_flag) begin
               o_ctrl.alu_op  = ALU_ADD;
               o_ctrl.imm_sel = IMM_5;
               o_ctrl.rf_we   = 1'b1;
               o_ctrl.nzp_we  = 1'b1;
            end else if (subop == SUBOP_ADD || subop == SUBOP_SUB) begin
               o_ctrl.alu_op = (subop == SUBOP_SUB) ? ALU_SUB : ALU_ADD;
               o_ctrl.rf_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
            end
         end
         OP_LOGIC: begin
            if (!imm_flag && subop == SUBOP_AND) begin
               o_ctrl.alu_op = ALU_AND;
               o_ctrl.rf_we  = 1'b1;
               o_ctrl.nzp_we = 1'b1;
            end
         end
         OP_LDR: begin
            o_ctrl.alu_op  = ALU_ADD;                    // rs + imm6
            o_ctrl.imm_sel = IMM_6;
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
            o_ctrl.is_load = 1'b1;
         end
         OP_STR: begin
            o_ctrl.alu_op   = ALU_ADD;
            o_ctrl.imm_sel  = IMM_6;
            o_ctrl.r2sel    = i_insn[RD_LSB +: 3];       // Data register sits in the rd field
            o_ctrl.is_store = 1'b1;
         end
         OP_CONST: begin
            o_ctrl.imm_sel = IMM_9;
            o_ctrl.rf_we   = 1'b1;
            o_ctrl.nzp_we  = 1'b1;
         end
         default: ;                                      // Retires as a no-op
      endcase
   end

endmodule

// File: src/lc4_execute_stage.sv
// Execute stage with operand bypass, ALU, NZP generation and the memory register
module lc4_execute_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic   gwe,
   input  logic   i_rst_n,
   input  x_reg_t i_x_reg,
   input  fwd_t   i_m_fwd,
   input  fwd_t   i_w_fwd,
   output m_reg_t o_m_reg,
   output fwd_t   o_x_fwd,
   output logic   o_take_branch,
   output word_t  o_target
);

   word_t  r1;
   word_t  r2;
   word_t  imm;
   word_t  opb;
   word_t  result;
   nzp_t   nzp;
   m_reg_t m_q;

   // Memory result first, loads excluded, then writeback
   function automatic word_t bypass(reg_sel_t sel, word_t reg_data, fwd_t m, fwd_t w);
      if (m.rf_we && !m.is_load && m.wsel == sel) return m.data;
      else if (w.rf_we && w.wsel == sel) return w.data;
      else return reg_data;
   endfunction

   always_comb begin
      r1 = bypass(i_x_reg.ctrl.r1sel, i_x_reg.r1_data, i_m_fwd, i_w_fwd);
      r2 = bypass(i_x_reg.ctrl.r2sel, i_x_reg.r2_data, i_m_fwd, i_w_fwd);
      case (i_x_reg.ctrl.imm_sel)
         IMM_5:   imm = word_t'($signed(i_x_reg.insn[IMM5_W-1:0]));
         IMM_6:   imm = word_t'($signed(i_x_reg.insn[IMM6_W-1:0]));
         IMM_9:   imm = word_t'($signed(i_x_reg.insn[IMM9_W-1:0]));
         default: imm = '0;
      endcase
      opb = (i_x_reg.ctrl.imm_sel == IMM_NONE) ? r2 : imm;
      case (i_x_reg.ctrl.alu_op)
         ALU_ADD:       result = r1 + opb;    // Also load and store address
         ALU_SUB:       result = r1 - opb;
         ALU_AND:       result = r1 & opb;
         ALU_BR_TARGET: result = i_x_reg.pc + 16'd1 + imm;
         default:       result = imm;         // CONST
      endcase
   end

   assign nzp = nzp_of(result);

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         m_q       <= '0;
         m_q.stall <= ST_FLUSH;
      end else begin
         m_q <= '{insn: i_x_reg.insn, pc: i_x_reg.pc, stall: i_x_reg.stall,
                  ctrl: i_x_reg.ctrl, alu: result, r2_data: r2, nzp: nzp};
      end
   end

   assign o_x_fwd = '{rf_we: i_x_reg.ctrl.rf_we, wsel: i_x_reg.ctrl.wsel, data: result,
                      is_load: i_x_reg.ctrl.is_load, nzp_we: i_x_reg.ctrl.nzp_we, nzp: nzp};

   assign o_take_branch = i_x_reg.take_branch;
   assign o_target      = result;
   assign o_m_reg       = m_q;

endmodule

// File: src/lc4_fetch.sv
// Fetch stage with PC register, next-PC select and the decode pipeline register
module lc4_fetch import isa_pkg::*, pipe_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200
) (
   input  logic   gwe,
   input  logic   i_rst_n,
   input  word_t  i_imem_data,
   input  logic   i_load_use,
   input  logic   i_branch_taken_d,
   input  logic   i_branch_taken_x,
   input  word_t  i_target,
   output word_t  o_imem_addr,
   output d_reg_t o_d_reg
);

   word_t  pc_q;
   word_t  next_pc;
   d_reg_t d_q;

   assign next_pc = i_load_use       ? pc_q     :  // Refetch the same word
                    i_branch_taken_x ? i_target :
                                       pc_q + 16'd1;

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         pc_q      <= RESET_PC;
         d_q       <= '0;
         d_q.stall <= ST_FLUSH;
      end else begin
         pc_q <= next_pc;
         if (!i_load_use) begin
            d_q.insn  <= i_imem_data;
            d_q.pc    <= pc_q;
            // Wrong-path words behind a taken branch
            d_q.stall <= (i_branch_taken_d || i_branch_taken_x) ? ST_FLUSH : ST_NONE;
         end
      end
   end

   assign o_imem_addr = pc_q;
   assign o_d_reg     = d_q;

endmodule

// File: src/lc4_mem_wb.sv
// Memory and writeback stages with data-memory drive, writeback select, NZP register and trace
module lc4_mem_wb import isa_pkg::*, pipe_pkg::*; (
   input  logic   gwe,
   input  logic   i_rst_n,
   input  m_reg_t i_m_reg,
   input  word_t  i_dmem_rdata,
   output word_t  o_dmem_addr,
   output logic   o_dmem_we,
   output word_t  o_dmem_wdata,
   output fwd_t   o_m_fwd,
   output fwd_t   o_w_fwd,
   output nzp_t   o_nzp_reg,
   output trace_t o_trace
);

   nzp_t   m_nzp;
   w_reg_t w_q;
   word_t  wdata;
   nzp_t   nzp_q;

   assign o_dmem_addr  = i_m_reg.alu;
   assign o_dmem_we    = i_m_reg.ctrl.is_store;
   assign o_dmem_wdata = i_m_reg.r2_data;

   // Loads take their NZP from the word memory returns
   assign m_nzp = i_m_reg.ctrl.is_load ? nzp_of(i_dmem_rdata) : i_m_reg.nzp;

   assign o_m_fwd = '{rf_we: i_m_reg.ctrl.rf_we, wsel: i_m_reg.ctrl.wsel, data: i_m_reg.alu,
                      is_load: i_m_reg.ctrl.is_load, nzp_we: i_m_reg.ctrl.nzp_we, nzp: m_nzp};

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         w_q       <= '0;
         w_q.stall <= ST_FLUSH;
         nzp_q     <= '0;
      end else begin
         w_q <= '{insn: i_m_reg.insn, pc: i_m_reg.pc, stall: i_m_reg.stall, ctrl: i_m_reg.ctrl,
                  alu: i_m_reg.alu, load_data: i_dmem_rdata, nzp: m_nzp};
         if (w_q.ctrl.nzp_we) nzp_q <= w_q.nzp;
      end
   end

   assign wdata = w_q.ctrl.is_load ? w_q.load_data : w_q.alu;

   assign o_w_fwd = '{rf_we: w_q.ctrl.rf_we, wsel: w_q.ctrl.wsel, data: wdata,
                      is_load: w_q.ctrl.is_load, nzp_we: w_q.ctrl.nzp_we, nzp: w_q.nzp};

   assign o_nzp_reg = nzp_q;

   // One record per cycle from the writeback register
   assign o_trace = '{stall: w_q.stall, pc: w_q.pc, insn: w_q.insn,
                      rf_we: w_q.ctrl.rf_we, wsel: w_q.ctrl.wsel, wdata: wdata,
                      nzp_we: w_q.ctrl.nzp_we, nzp: w_q.nzp};

endmodule

// File: src/lc4_pipe_core.sv
// Top level of the five-stage LC4 subset core, stage modules tied to the memory and trace ports
module lc4_pipe_core import isa_pkg::*, pipe_pkg::*; #(
   parameter word_t RESET_PC = 16'h8200
) (
   input  logic   gwe,
   input  logic   i_rst_n,
   input  word_t  i_imem_data,
   input  word_t  i_dmem_rdata,
   output word_t  o_imem_addr,
   output word_t  o_dmem_addr,
   output logic   o_dmem_we,
   output word_t  o_dmem_wdata,
   output trace_t o_trace
);

   d_reg_t d_reg;
   x_reg_t x_reg;
   m_reg_t m_reg;
   fwd_t   x_fwd;
   fwd_t   m_fwd;
   fwd_t   w_fwd;
   nzp_t   nzp_reg;
   logic   load_use;
   logic   branch_taken_d;
   logic   branch_taken_x;
   word_t  target;

   lc4_fetch #(
      .RESET_PC (RESET_PC)
   ) u_fetch (
      .gwe              (gwe),
      .i_rst_n          (i_rst_n),
      .i_imem_data      (i_imem_data),
      .i_load_use       (load_use),
      .i_branch_taken_d (branch_taken_d),
      .i_branch_taken_x (branch_taken_x),
      .i_target         (target),
      .o_imem_addr      (o_imem_addr),
      .o_d_reg          (d_reg)
   );

   lc4_decode_stage u_decode (
      .gwe            (gwe),
      .i_rst_n        (i_rst_n),
      .i_d_reg        (d_reg),
      .i_x_fwd        (x_fwd),
      .i_m_fwd        (m_fwd),
      .i_w_fwd        (w_fwd),
      .i_nzp_reg      (nzp_reg),
      .o_x_reg        (x_reg),
      .o_load_use     (load_use),
      .o_branch_taken (branch_taken_d)
   );

   lc4_execute_stage u_execute (
      .gwe           (gwe),
      .i_rst_n       (i_rst_n),
      .i_x_reg       (x_reg),
      .i_m_fwd       (m_fwd),
      .i_w_fwd       (w_fwd),
      .o_m_reg       (m_reg),
      .o_x_fwd       (x_fwd),
      .o_take_branch (branch_taken_x),
      .o_target      (target)
   );

   lc4_mem_wb u_mem_wb (
      .gwe          (gwe),
      .i_rst_n      (i_rst_n),
      .i_m_reg      (m_reg),
      .i_dmem_rdata (i_dmem_rdata),
      .o_dmem_addr  (o_dmem_addr),
      .o_dmem_we    (o_dmem_we),
      .o_dmem_wdata (o_dmem_wdata),
      .o_m_fwd      (m_fwd),
      .o_w_fwd      (w_fwd),
      .o_nzp_reg    (nzp_reg),
      .o_trace      (o_trace)
   );

endmodule

// File: src/lc4_regfile.sv
// Register file, eight 16-bit registers with two asynchronous reads and one write
module lc4_regfile import isa_pkg::*; (
   input  logic     gwe,
   input  logic     i_rst_n,
   input  reg_sel_t i_rs,
   input  reg_sel_t i_rt,
   input  reg_sel_t i_rd,
   input  word_t    i_wdata,
   input  logic     i_rd_we,
   output word_t    o_rs_data,
   output word_t    o_rt_data
);

   word_t regs [8];

   always_ff @(posedge gwe) begin
      if (!i_rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // Same-cycle writes are bypassed by the decode stage
   assign o_rs_data = regs[i_rs];
   assign o_rt_data = regs[i_rt];

endmodule

// File: src/pipe_pkg.sv
// Pipeline stall codes, decoded control struct, stage register structs and retire trace
package pipe_pkg;

   import isa_pkg::*;

   typedef enum logic [1:0] {
      ST_NONE     = 2'd0,
      ST_FLUSH    = 2'd2,  // Squashed, or reset
      ST_LOAD_USE = 2'd3
   } stall_t;

   typedef struct packed {
      alu_op_t  alu_op;
      imm_sel_t imm_sel;
      logic     rf_we;
      reg_sel_t wsel;
      reg_sel_t r1sel;
      reg_sel_t r2sel;
      logic     nzp_we;
      logic     is_load;
      logic     is_store;
      logic     is_branch;
   } ctrl_t;

   typedef struct packed {
      word_t  insn;
      word_t  pc;
      stall_t stall;
   } d_reg_t;

   typedef struct packed {
      word_t  insn;
      word_t  pc;
      stall_t stall;
      ctrl_t  ctrl;
      word_t  r1_data;
      word_t  r2_data;
      logic   take_branch;
   } x_reg_t;

   typedef struct packed {
      word_t  insn;
      word_t  pc;
      stall_t stall;
      ctrl_t  ctrl;
      word_t  alu;
      word_t  r2_data;     // Store data
      nzp_t   nzp;
   } m_reg_t;

   typedef struct packed {
      word_t  insn;
      word_t  pc;
      stall_t stall;
      ctrl_t  ctrl;
      word_t  alu;
      word_t  load_data;
      nzp_t   nzp;
   } w_reg_t;

   // Pending write of one stage, seen by hazard and bypass logic
   typedef struct packed {
      logic     rf_we;
      reg_sel_t wsel;
      word_t    data;
      logic     is_load;
      logic     nzp_we;
      nzp_t     nzp;
   } fwd_t;

   typedef struct packed {
      stall_t   stall;
      word_t    pc;
      word_t    insn;
      logic     rf_we;
      reg_sel_t wsel;
      word_t    wdata;
      logic     nzp_we;
      nzp_t     nzp;
   } trace_t;

endpackage
